/* include/dbg_bus_cfg.svh */
`ifndef DBG_BUS_CFG_SVH
`define DBG_BUS_CFG_SVH

// Bus and shared register widths
`define DBG_ADDR_W      32
`define DBG_DATA_W      32
`define DBG_DREG_W      64     // Shared TAP data register
`define DBG_COUNT_W     16     // Burst length in words
`define DBG_BITCNT_W    6      // Counts up to 32 for the write CRC
`define DBG_CRC_W       32
`define DBG_CRC_POLY    32'hedb88320  // Reflected CRC-32 polynomial

// Command field positions in the data register
`define DBG_OP_W        4
`define DBG_OP_MSB      62
`define DBG_ADDR_MSB    58
`define DBG_COUNT_MSB   26
`define DBG_CLR_BIT     57     // Set in IREG_WR data to clear the error flag

// Opcode values
`define DBG_OP_BWRITE32 4'd3
`define DBG_OP_BREAD32  4'd7
`define DBG_OP_IREG_WR  4'd9

`endif

/* source/dbg_bus_pkg.sv */
`include "dbg_bus_cfg.svh"

package dbg_bus_pkg;

  // Vector types with a fixed meaning
  typedef logic [`DBG_ADDR_W-1:0]   dbg_addr_t;    // Bus address
  typedef logic [`DBG_DATA_W-1:0]   dbg_data_t;    // Bus data word
  typedef logic [`DBG_DREG_W-1:0]   dbg_dreg_t;    // Shared TAP data register
  typedef logic [`DBG_COUNT_W-1:0]  dbg_count_t;   // Words left in burst
  typedef logic [`DBG_CRC_W-1:0]    dbg_crc_t;
  typedef logic [`DBG_BITCNT_W-1:0] dbg_bitcnt_t;  // Bit position in word
  typedef logic [`DBG_ADDR_W:0]     dbg_errreg_t;  // Address in 32..1, flag in bit 0

  // Command opcodes
  typedef enum logic [`DBG_OP_W-1:0] {
    OP_BWRITE32 = `DBG_OP_BWRITE32,
    OP_BREAD32  = `DBG_OP_BREAD32,
    OP_IREG_WR  = `DBG_OP_IREG_WR
  } dbg_opcode_e;

  // Burst control FSM
  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,
    ST_RBEGIN  = 4'd1,   // First read strobe
    ST_RREADY  = 4'd2,   // Wait for capture
    ST_RSTATUS = 4'd3,   // Ready bit out on TDO
    ST_RBURST  = 4'd4,
    ST_RCRC    = 4'd5,
    ST_WREADY  = 4'd6,
    ST_WWAIT   = 4'd7,   // Wait for start bit
    ST_WBURST  = 4'd8,
    ST_WCRC    = 4'd9,
    ST_WMATCH  = 4'd10
  } dbg_state_e;

  // TDO source select
  typedef enum logic [1:0] {
    TDO_RDY   = 2'd0,
    TDO_DATA  = 2'd1,
    TDO_MATCH = 2'd2,
    TDO_CRC   = 2'd3
  } dbg_tdo_sel_e;

endpackage

/* source/dbg_ctrl_if.sv */
`timescale 1ns/1ps

interface dbg_ctrl_if import dbg_bus_pkg::*; ();

  // Control strobes, FSM to datapath
  logic         addr_ld;      // Load start address from command
  logic         addr_inc;     // Step address by one word
  logic         word_ld;      // Load word count from command
  logic         word_dec;
  logic         bit_clr;
  logic         bit_inc;
  logic         out_ld;       // Parallel load of output shift register
  logic         out_sel_bus;  // 1 = BIU read data, 0 = error register
  logic         out_shift;
  logic         err_chk;      // Sample ready/error into error flag
  logic         err_clr;      // Internal register write
  logic         crc_clr;
  logic         crc_en;
  logic         crc_in_tdi;   // CRC over TDI instead of read data
  logic         crc_shift;
  logic         strb;         // Same pulse as biu_strb_o
  dbg_tdo_sel_e tdo_sel;

  // Status flags, datapath to FSM
  logic         word_zero;
  logic         word_last;    // Count is 1
  logic         bit_max;      // Last bit of a word
  logic         bit_32;       // CRC fully shifted in
  logic         crc_match;

  modport fsm_mp (
    output addr_ld, addr_inc, word_ld, word_dec, bit_clr, bit_inc,
           out_ld, out_sel_bus, out_shift, err_chk, err_clr,
           crc_clr, crc_en, crc_in_tdi, crc_shift, strb, tdo_sel,
    input  word_zero, word_last, bit_max, bit_32, crc_match
  );

  modport dp_mp (
    input  addr_ld, addr_inc, word_ld, word_dec, bit_clr, bit_inc,
           out_ld, out_sel_bus, out_shift, err_chk, err_clr,
           crc_clr, crc_en, crc_in_tdi, crc_shift, strb, tdo_sel,
    output word_zero, word_last, bit_max, bit_32, crc_match
  );

endinterface

/* source/dbg_crc32.sv */
`timescale 1ns/1ps
`include "dbg_bus_cfg.svh"

module dbg_crc32 import dbg_bus_pkg::*; (
  input  logic     dbg_clk,
  input  logic     dbg_rst,
  input  logic     data_i,    // Serial data, one bit per enable
  input  logic     enable_i,
  input  logic     shift_i,   // Shift value out through serial_o
  input  logic     clr_i,     // Back to all ones
  output dbg_crc_t crc_o,
  output logic     serial_o
);

  dbg_crc_t crc_q;
  logic     fb;              // Feedback bit

  assign fb = data_i ^ crc_q[0];

  ////////////////////////////////////////////////////////////////////////////
  // LSB-first CRC register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;
    end else if (enable_i) begin
      // Shift right, fold in polynomial on feedback
      crc_q <= (crc_q >> 1) ^ (fb ? dbg_crc_t'(`DBG_CRC_POLY) : '0);
    end else if (shift_i) begin
      crc_q <= crc_q >> 1;   // Zero fill from the top
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];  // Next bit to TDO

endmodule

/* source/dbg_burst_fsm.sv */
`timescale 1ns/1ps
`include "dbg_bus_cfg.svh"

module dbg_burst_fsm import dbg_bus_pkg::*; (
  input  logic       dbg_clk,
  input  logic       dbg_rst,
  input  logic       capture_dr_i,
  input  logic       shift_dr_i,
  input  logic       update_dr_i,
  input  logic       module_select_i,
  input  logic       biu_rdy_i,
  input  dbg_dreg_t  data_register_i,
  output logic       biu_rw_o,
  output logic       biu_strb_o,
  output logic       biu_clr_err_o,
  output logic       inhibit_o,
  dbg_ctrl_if.fsm_mp ctrl
);

  dbg_state_e  state_q, state_d;
  dbg_opcode_e opcode;
  logic        module_cmd;   // MSB clear means command for this module
  logic        start_bit;    // First bit of a write burst, seen at MSB
  logic        cmd_go;       // Command update for this module
  logic        rd_go, wr_go;
  logic        rd_op_q;      // Latched read/write direction
  logic        rd_word_end;  // Read word finished, load the next one
  logic        strb;

  ////////////////////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////////////////////

  assign module_cmd = ~data_register_i[`DBG_DREG_W-1];
  assign start_bit  = data_register_i[`DBG_DREG_W-1];
  assign opcode     = dbg_opcode_e'(data_register_i[`DBG_OP_MSB -: `DBG_OP_W]);
  assign cmd_go     = module_select_i & module_cmd & update_dr_i;
  assign rd_go      = cmd_go & (opcode == OP_BREAD32);
  assign wr_go      = cmd_go & (opcode == OP_BWRITE32);

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      rd_op_q <= 1'b0;
    end else if (rd_go | wr_go) begin
      rd_op_q <= rd_go;   // Held for the whole burst
    end
  end

  assign biu_rw_o = rd_op_q;

  ////////////////////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (rd_go) begin
          state_d = ST_RBEGIN;
        end else if (wr_go) begin
          state_d = ST_WREADY;
        end
      end
      ST_RBEGIN:  state_d = ctrl.word_zero ? ST_IDLE : ST_RREADY;  // Zero-length burst
      ST_RREADY:  if (module_select_i & capture_dr_i) state_d = ST_RSTATUS;
      ST_RSTATUS: begin
        if (update_dr_i) begin
          state_d = ST_IDLE;          // Early exit
        end else if (biu_rdy_i) begin
          state_d = ST_RBURST;
        end
      end
      ST_RBURST: begin
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (ctrl.bit_max & ctrl.word_zero) begin
          state_d = ST_RCRC;
        end
      end
      ST_RCRC:    if (update_dr_i) state_d = ST_IDLE;  // Stays until update
      ST_WREADY: begin
        if (ctrl.word_zero) begin
          state_d = ST_IDLE;
        end else if (module_select_i & capture_dr_i) begin
          state_d = ST_WWAIT;
        end
      end
      ST_WWAIT: begin
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (module_select_i & start_bit) begin
          state_d = ST_WBURST;
        end
      end
      ST_WBURST: begin
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (ctrl.bit_max & ctrl.word_zero) begin
          state_d = ST_WCRC;
        end
      end
      ST_WCRC: begin
        if (update_dr_i) begin
          state_d = ST_IDLE;
        end else if (ctrl.bit_32) begin
          state_d = ST_WMATCH;
        end
      end
      ST_WMATCH:  if (update_dr_i) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control outputs
  ////////////////////////////////////////////////////////////////////////////

  assign rd_word_end = ((state_q == ST_RSTATUS) & ~update_dr_i & biu_rdy_i) |
                       ((state_q == ST_RBURST) & ctrl.bit_max);

  always_comb begin
    ctrl.addr_ld     = 1'b0;
    ctrl.addr_inc    = 1'b0;
    ctrl.word_ld     = 1'b0;
    ctrl.word_dec    = 1'b0;
    ctrl.bit_clr     = 1'b0;
    ctrl.bit_inc     = 1'b0;
    ctrl.out_ld      = 1'b0;
    ctrl.out_sel_bus = 1'b0;
    ctrl.out_shift   = 1'b0;
    ctrl.err_chk     = 1'b0;
    ctrl.err_clr     = 1'b0;
    ctrl.crc_clr     = 1'b0;
    ctrl.crc_en      = 1'b0;
    ctrl.crc_in_tdi  = 1'b0;
    ctrl.crc_shift   = 1'b0;
    ctrl.tdo_sel     = TDO_DATA;
    strb             = 1'b0;
    biu_clr_err_o    = 1'b0;
    inhibit_o        = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        ctrl.out_shift = module_select_i & shift_dr_i;     // Error register readout
        ctrl.out_ld    = module_select_i & capture_dr_i;
        ctrl.err_clr   = cmd_go & (opcode == OP_IREG_WR);
        if (rd_go | wr_go) begin                          // Same setup for both
          ctrl.addr_ld = 1'b1;
          ctrl.word_ld = 1'b1;
          ctrl.bit_clr = 1'b1;
          ctrl.crc_clr = 1'b1;
        end
      end
      ST_RBEGIN: begin
        strb          = ~ctrl.word_zero;
        ctrl.addr_inc = ~ctrl.word_zero;
      end
      ST_RSTATUS: begin
        ctrl.tdo_sel = TDO_RDY;
        inhibit_o    = 1'b1;
      end
      ST_RBURST: begin
        ctrl.out_shift = 1'b1;
        ctrl.bit_inc   = 1'b1;
        ctrl.crc_en    = 1'b1;      // CRC over bits leaving on TDO
        inhibit_o      = 1'b1;
      end
      ST_RCRC: begin
        ctrl.tdo_sel   = TDO_CRC;
        ctrl.crc_shift = 1'b1;
        inhibit_o      = 1'b1;
      end
      ST_WWAIT: begin
        inhibit_o = 1'b1;
        if (module_select_i & start_bit) begin
          biu_clr_err_o   = 1'b1;  // Drop stale error from last burst
          ctrl.bit_inc    = 1'b1;  // TDI already holds data bit 0
          ctrl.word_dec   = 1'b1;
          ctrl.crc_en     = 1'b1;
          ctrl.crc_in_tdi = 1'b1;
        end
      end
      ST_WBURST: begin
        ctrl.bit_inc    = 1'b1;
        ctrl.crc_en     = 1'b1;
        ctrl.crc_in_tdi = 1'b1;
        inhibit_o       = 1'b1;
        if (ctrl.bit_max) begin
          ctrl.err_chk  = 1'b1;    // Previous word must be done
          ctrl.bit_clr  = 1'b1;
          strb          = 1'b1;
          ctrl.addr_inc = 1'b1;
          ctrl.word_dec = 1'b1;
        end
      end
      ST_WCRC: begin
        ctrl.bit_inc = 1'b1;
        inhibit_o    = 1'b1;
        if (ctrl.bit_32) ctrl.tdo_sel = TDO_MATCH;  // Match bit read here
      end
      ST_WMATCH: begin
        ctrl.tdo_sel = TDO_MATCH;
        ctrl.err_chk = update_dr_i;  // Last write checked on the way out
        inhibit_o    = 1'b1;
      end
      default: ;
    endcase

    if (rd_word_end) begin
      ctrl.err_chk     = 1'b1;
      ctrl.out_ld      = 1'b1;
      ctrl.out_sel_bus = 1'b1;
      ctrl.bit_clr     = 1'b1;
      ctrl.word_dec    = 1'b1;
      if (~ctrl.word_last & ~ctrl.word_zero) begin  // Prefetch next word
        strb          = 1'b1;
        ctrl.addr_inc = 1'b1;
      end
    end
  end

  assign ctrl.strb  = strb;
  assign biu_strb_o = strb;

endmodule

/* source/dbg_bus_datapath.sv */
`timescale 1ns/1ps
`include "dbg_bus_cfg.svh"

module dbg_bus_datapath import dbg_bus_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  logic      dbg_tdi_i,
  output logic      dbg_tdo_o,
  input  dbg_dreg_t data_register_i,
  input  dbg_data_t biu_data_i,
  input  logic      biu_rdy_i,
  input  logic      biu_err_i,
  output dbg_addr_t biu_addr_o,
  output dbg_data_t biu_data_o,
  dbg_ctrl_if.dp_mp ctrl
);

  dbg_addr_t   addr_q;      // Address of next transfer
  dbg_count_t  word_q;      // Words left
  dbg_bitcnt_t bit_q;
  dbg_errreg_t out_q;       // Wide enough for the error register
  dbg_errreg_t err_q;
  dbg_addr_t   cmd_addr;
  dbg_count_t  cmd_count;
  dbg_crc_t    crc_val;
  logic        crc_din;
  logic        crc_ser;

  assign cmd_addr  = data_register_i[`DBG_ADDR_MSB -: `DBG_ADDR_W];
  assign cmd_count = data_register_i[`DBG_COUNT_MSB -: `DBG_COUNT_W];

  ////////////////////////////////////////////////////////////////////////////
  // Address, word and bit counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      addr_q <= '0;
      word_q <= '0;
      bit_q  <= '0;
    end else begin
      if (ctrl.addr_ld) begin
        addr_q <= cmd_addr;
      end else if (ctrl.addr_inc) begin
        addr_q <= addr_q + dbg_addr_t'(`DBG_DATA_W / 8);  // Always one word
      end
      if (ctrl.word_ld) begin
        word_q <= cmd_count;
      end else if (ctrl.word_dec) begin
        word_q <= word_q - 1'b1;
      end
      if (ctrl.bit_clr) begin
        bit_q <= '0;
      end else if (ctrl.bit_inc) begin
        bit_q <= bit_q + 1'b1;
      end
    end
  end

  assign ctrl.word_zero = (word_q == '0);
  assign ctrl.word_last = (word_q == dbg_count_t'(1));
  assign ctrl.bit_max   = (bit_q == dbg_bitcnt_t'(`DBG_DATA_W - 1));
  assign ctrl.bit_32    = (bit_q == dbg_bitcnt_t'(`DBG_CRC_W));

  ////////////////////////////////////////////////////////////////////////////
  // Error register and output shift register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      err_q <= '0;
    end else if (ctrl.err_clr) begin
      if (data_register_i[`DBG_CLR_BIT]) err_q[0] <= 1'b0;
    end else if (!err_q[0]) begin          // Frozen once flagged
      if (ctrl.err_chk && (biu_err_i || !biu_rdy_i)) begin
        err_q[0] <= 1'b1;                  // Late or failed transfer
      end else if (ctrl.strb) begin
        err_q[`DBG_ADDR_W:1] <= addr_q;
      end
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      out_q <= '0;
    end else if (ctrl.out_ld) begin
      out_q <= ctrl.out_sel_bus ? {1'b0, biu_data_i} : err_q;
    end else if (ctrl.out_shift) begin
      out_q <= out_q >> 1;                 // LSB first
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // CRC and TDO
  ////////////////////////////////////////////////////////////////////////////

  assign crc_din = ctrl.crc_in_tdi ? dbg_tdi_i : out_q[0];  // Write or read data

  dbg_crc32 crc_i (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .data_i   (crc_din),
    .enable_i (ctrl.crc_en),
    .shift_i  (ctrl.crc_shift),
    .clr_i    (ctrl.crc_clr),
    .crc_o    (crc_val),
    .serial_o (crc_ser)
  );

  // Host CRC sits in the upper half once shifted in
  assign ctrl.crc_match = (data_register_i[`DBG_DREG_W-1 -: `DBG_CRC_W] == crc_val);

  always_comb begin
    unique case (ctrl.tdo_sel)
      TDO_RDY:   dbg_tdo_o = biu_rdy_i;
      TDO_DATA:  dbg_tdo_o = out_q[0];
      TDO_MATCH: dbg_tdo_o = ctrl.crc_match;
      default:   dbg_tdo_o = crc_ser;
    endcase
  end

  // BIU side, latched by the BIU on strobe
  assign biu_addr_o = addr_q;
  assign biu_data_o = {dbg_tdi_i, data_register_i[`DBG_DREG_W-1 -: `DBG_DATA_W-1]};

endmodule

/* source/dbg_bus_core.sv */
`timescale 1ns/1ps

module dbg_bus_core import dbg_bus_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  logic      dbg_tdi_i,
  output logic      dbg_tdo_o,
  // TAP controller state
  input  logic      capture_dr_i,
  input  logic      shift_dr_i,
  input  logic      update_dr_i,
  input  logic      module_select_i,
  input  dbg_dreg_t data_register_i,   // Shared with other debug modules
  output logic      inhibit_o,
  // Bus interface unit
  input  dbg_data_t biu_data_i,
  input  logic      biu_rdy_i,
  input  logic      biu_err_i,
  output dbg_data_t biu_data_o,
  output dbg_addr_t biu_addr_o,
  output logic      biu_strb_o,
  output logic      biu_rw_o,
  output logic      biu_clr_err_o
);

  dbg_ctrl_if ctrl_bus ();   // FSM to datapath

  dbg_burst_fsm fsm_i (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .biu_rdy_i       (biu_rdy_i),
    .data_register_i (data_register_i),
    .biu_rw_o        (biu_rw_o),
    .biu_strb_o      (biu_strb_o),
    .biu_clr_err_o   (biu_clr_err_o),
    .inhibit_o       (inhibit_o),
    .ctrl            (ctrl_bus.fsm_mp)
  );

  dbg_bus_datapath dp_i (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .dbg_tdi_i       (dbg_tdi_i),
    .dbg_tdo_o       (dbg_tdo_o),
    .data_register_i (data_register_i),
    .biu_data_i      (biu_data_i),
    .biu_rdy_i       (biu_rdy_i),
    .biu_err_i       (biu_err_i),
    .biu_addr_o      (biu_addr_o),
    .biu_data_o      (biu_data_o),
    .ctrl            (ctrl_bus.dp_mp)
  );

endmodule

/* bench/dbg_bus_tb.sv */
`timescale 1ns/1ps
`include "dbg_bus_cfg.svh"

module dbg_bus_tb import dbg_bus_pkg::*; ();

  localparam dbg_addr_t MEM_BASE = 32'h4000_1000;            // 64 words modeled
  localparam dbg_addr_t ERR_WIN  = MEM_BASE + 32'h0000_00c0;  // Four words answer with error

  logic        dbg_clk;
  logic        dbg_rst;
  logic        tdi;
  logic        tdo;
  logic        capture_dr;
  logic        shift_dr;
  logic        update_dr;
  logic        module_select;
  dbg_dreg_t   dreg;           // TAP data register model
  logic        inhibit;
  dbg_data_t   biu_rdata;
  dbg_data_t   biu_wdata;
  dbg_addr_t   biu_addr;
  logic        biu_rdy;
  logic        biu_err;
  logic        biu_strb;
  logic        biu_rw;
  logic        biu_clr_err;

  logic [31:0] lfsr_q;
  logic        tdo_s;          // Sampled on the falling edge
  logic        inh_s;
  logic        clr_s;
  logic        expect_rw;      // Direction the next strobes must carry
  dbg_data_t   mem [64];

  // Bus model state
  logic        bus_busy;
  int          bus_wait;
  dbg_addr_t   bus_addr;
  logic        bus_rw;
  dbg_data_t   bus_wdata;
  logic [31:0] bus_dly;
  logic        rdy_n;
  logic        err_n;
  dbg_data_t   rdata_n;

  dbg_bus_core dut_i (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .dbg_tdi_i       (tdi),
    .dbg_tdo_o       (tdo),
    .capture_dr_i    (capture_dr),
    .shift_dr_i      (shift_dr),
    .update_dr_i     (update_dr),
    .module_select_i (module_select),
    .data_register_i (dreg),
    .inhibit_o       (inhibit),
    .biu_data_i      (biu_rdata),
    .biu_rdy_i       (biu_rdy),
    .biu_err_i       (biu_err),
    .biu_data_o      (biu_wdata),
    .biu_addr_o      (biu_addr),
    .biu_strb_o      (biu_strb),
    .biu_rw_o        (biu_rw),
    .biu_clr_err_o   (biu_clr_err)
  );

  initial begin
    dbg_clk = 1'b0;
    forever #2 dbg_clk = ~dbg_clk;   // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers, reference models, checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s >> 1;
    if (s[0]) lfsr_step = lfsr_step ^ 32'h8020_0003;   // x^32+x^22+x^2+x+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[i]   = lfsr_q[0];          // One step per bit
    end
  endtask

  // Reflected CRC-32, one bit, no final inversion
  function automatic dbg_crc_t crc_bit(input dbg_crc_t c, input logic d);
    crc_bit = c >> 1;
    if (d ^ c[0]) crc_bit = crc_bit ^ `DBG_CRC_POLY;
  endfunction

  function automatic dbg_data_t mem_fill(input dbg_addr_t a);
    mem_fill = (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic dbg_dreg_t make_cmd(input dbg_opcode_e op, input dbg_addr_t a,
                                         input dbg_count_t n);
    make_cmd = '0;                                   // MSB 0 selects this module
    make_cmd[`DBG_OP_MSB -: `DBG_OP_W]       = op;
    make_cmd[`DBG_ADDR_MSB -: `DBG_ADDR_W]   = a;
    make_cmd[`DBG_COUNT_MSB -: `DBG_COUNT_W] = n;
  endfunction

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input dbg_data_t got, input dbg_data_t exp, input string what);
    if (got !== exp) report_fail($sformatf("[FAIL] %0t: %s got %h expected %h",
                                           $time, what, got, exp));
  endtask

  task automatic check_crc(input dbg_crc_t got, input dbg_crc_t exp, input string what);
    if (got !== exp) report_fail($sformatf("[FAIL] %0t: %s got %h expected %h",
                                           $time, what, got, exp));
  endtask

  task automatic check_errreg(input dbg_errreg_t got, input dbg_errreg_t exp,
                              input string what);
    if (got !== exp) report_fail($sformatf("[FAIL] %0t: %s got %h expected %h",
                                           $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_fail($sformatf("[FAIL] %0t: %s got %b expected %b",
                                           $time, what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus model, ready drops on strobe and returns 1 to 4 cycles later
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge dbg_clk) begin
    rdy_n   = biu_rdy;
    err_n   = biu_err;
    rdata_n = biu_rdata;
    if (biu_clr_err) err_n = 1'b0;                 // Stale error dropped
    if (biu_strb) begin
      if (bus_busy) report_fail("Bus strobe came before the previous transfer finished");
      if (biu_addr[31:8] != MEM_BASE[31:8]) report_fail("Bus access outside the memory model");
      check_bit(biu_rw, expect_rw, "biu_rw_o at strobe");
      rand_bits(2, bus_dly);
      bus_wait  = bus_dly + 1;
      bus_busy  = 1'b1;
      bus_addr  = biu_addr;
      bus_rw    = biu_rw;
      bus_wdata = biu_wdata;
      rdy_n     = 1'b0;
      err_n     = 1'b0;
    end else if (bus_busy) begin
      bus_wait = bus_wait - 1;
      if (bus_wait == 0) begin
        bus_busy = 1'b0;
        rdy_n    = 1'b1;
        err_n    = (bus_addr[31:4] == ERR_WIN[31:4]);
        if (bus_rw) rdata_n = mem[bus_addr[7:2]];
        else if (!err_n) mem[bus_addr[7:2]] = bus_wdata;   // Failed writes are lost
      end
    end
    #0.5;
    biu_rdy   = rdy_n;
    biu_err   = err_n;
    biu_rdata = rdata_n;
  end

  ////////////////////////////////////////////////////////////////////////////
  // TAP sequences
  ////////////////////////////////////////////////////////////////////////////

  // One TCK cycle, entered and left 0.5 ns after the rising edge
  task automatic tap_cycle(input logic din, input logic sh, input logic cap, input logic upd);
    tdi        = din;
    shift_dr   = sh;
    capture_dr = cap;
    update_dr  = upd;
    @(negedge dbg_clk);
    tdo_s = tdo;
    inh_s = inhibit;
    clr_s = biu_clr_err;
    @(posedge dbg_clk);
    #0.5;
    if (sh) dreg = {din, dreg[`DBG_DREG_W-1:1]};  // TDI enters the MSB
  endtask

  task automatic pick_burst(output dbg_addr_t start, output int n);
    logic [31:0] r;
    rand_bits(3, r);
    n = r + 1;                                     // 1 to 8 words
    rand_bits(4, r);
    start = MEM_BASE + (r << 2);
  endtask

  task automatic read_errreg(input dbg_errreg_t exp);
    dbg_errreg_t got;
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);             // Capture in idle
    for (int b = 0; b < 33; b++) begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
      got[b] = tdo_s;
    end
    check_errreg(got, exp, "error register");
  endtask

  task automatic clear_error();
    dreg = make_cmd(OP_IREG_WR, '0, '0);
    dreg[`DBG_CLR_BIT] = 1'b1;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic burst_write(input dbg_addr_t start, input int n, input logic corrupt,
                             input logic store);
    dbg_data_t   words [8];
    dbg_crc_t    crc;
    logic [31:0] flip;
    expect_rw = 1'b0;
    crc       = '1;
    for (int k = 0; k < n; k++) begin
      rand_bits(32, words[k]);
      for (int b = 0; b < 32; b++) crc = crc_bit(crc, words[k][b]);
    end
    if (corrupt) begin
      rand_bits(5, flip);
      crc[flip[4:0]] = ~crc[flip[4:0]];            // One bad bit on the wire
    end
    dreg = make_cmd(OP_BWRITE32, start, dbg_count_t'(n));
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b1);             // Command
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);             // Capture
    tap_cycle(1'b1, 1'b1, 1'b0, 1'b0);             // Start bit
    for (int k = 0; k < n; k++) begin
      for (int b = 0; b < 32; b++) begin
        tap_cycle(words[k][b], 1'b1, 1'b0, 1'b0);
        check_bit(inh_s, 1'b1, "inhibit_o while shifting write data");
        check_bit(clr_s, k == 0 && b == 0, "biu_clr_err_o around start bit");
      end
    end
    for (int b = 0; b < 32; b++) tap_cycle(crc[b], 1'b1, 1'b0, 1'b0);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);             // Match bit on TDO
    check_bit(tdo_s, ~corrupt, "write CRC match bit");
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b1);
    if (store) begin
      for (int k = 0; k < n; k++) check_data(mem[start[7:2] + k], words[k], "memory word");
    end
  endtask

  // cut_bits of 0 runs the full burst
  task automatic burst_read(input dbg_addr_t start, input int n, input int cut_bits);
    dbg_data_t exp;
    dbg_data_t got;
    dbg_crc_t  crc;
    dbg_crc_t  rcrc;
    logic      cut;
    int        t;
    expect_rw = 1'b1;
    crc       = '1;
    cut       = 1'b0;
    dreg = make_cmd(OP_BREAD32, start, dbg_count_t'(n));
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b1);             // Command
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);             // First strobe goes out
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);             // Capture
    tdo_s = 1'b0;                                  // Status only counts in shift cycles
    for (t = 0; t < 40 && !tdo_s; t++) tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    if (!tdo_s) report_fail("Timeout waiting for the read status bit");
    for (int k = 0; k < n && !cut; k++) begin
      exp = mem[start[7:2] + k];
      for (int b = 0; b < 32 && !cut; b++) begin
        if (cut_bits != 0 && k * 32 + b == cut_bits) begin
          cut = 1'b1;
        end else begin
          tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
          got[b] = tdo_s;
          crc    = crc_bit(crc, exp[b]);
        end
      end
      if (!cut) check_data(got, exp, "read word");
    end
    if (cut) begin
      tap_cycle(1'b0, 1'b0, 1'b0, 1'b1);           // Early update
      tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      check_bit(inh_s, 1'b0, "inhibit_o after early update");
    end else begin
      for (int b = 0; b < 32; b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
        rcrc[b] = tdo_s;
      end
      check_crc(rcrc, crc, "read CRC");
      tap_cycle(1'b0, 1'b0, 1'b0, 1'b1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    dbg_addr_t   start;
    int          n;
    logic [31:0] r;
    lfsr_q        = 32'he15;
    tdi           = 1'b0;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b1;
    dreg          = '0;
    biu_rdata     = '0;
    biu_rdy       = 1'b1;                          // Bus idle and ready
    biu_err       = 1'b0;
    bus_busy      = 1'b0;
    expect_rw     = 1'b0;
    for (int i = 0; i < 64; i++) mem[i] = mem_fill(MEM_BASE + 4 * i);
    dbg_rst = 1'b1;
    repeat (5) @(posedge dbg_clk);
    #0.5;
    dbg_rst = 1'b0;

    @(negedge dbg_clk);
    check_bit(biu_strb, 1'b0, "biu_strb_o after reset");
    check_bit(biu_clr_err, 1'b0, "biu_clr_err_o after reset");
    check_bit(inhibit, 1'b0, "inhibit_o after reset");
    @(posedge dbg_clk);
    #0.5;
    read_errreg('0);

    repeat (3) begin                               // Write then read back
      pick_burst(start, n);
      burst_write(start, n, 1'b0, 1'b1);
      burst_read(start, n, 0);
    end

    pick_burst(start, n);
    burst_write(start, n, 1'b1, 1'b1);             // Bad CRC

    rand_bits(2, r);                               // Error window
    start = ERR_WIN + (r << 2);
    burst_write(start, 1, 1'b0, 1'b0);
    read_errreg({start, 1'b1});
    clear_error();
    read_errreg({start, 1'b0});

    pick_burst(start, n);                          // Read cut short
    rand_bits(4, r);
    burst_read(start, n, r + 3);
    pick_burst(start, n);
    burst_write(start, n, 1'b0, 1'b1);
    burst_read(start, n, 0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* dbg_bus_core.f */
+incdir+include
source/dbg_bus_pkg.sv
source/dbg_ctrl_if.sv
source/dbg_crc32.sv
source/dbg_burst_fsm.sv
source/dbg_bus_datapath.sv
source/dbg_bus_core.sv
bench/dbg_bus_tb.sv

/* Bender.yml */
package:
  name: dbg_bus_core

export_include_dirs:
  - include

sources:
  - source/dbg_bus_pkg.sv
  - source/dbg_ctrl_if.sv
  - source/dbg_crc32.sv
  - source/dbg_burst_fsm.sv
  - source/dbg_bus_datapath.sv
  - source/dbg_bus_core.sv
  - target: test
    files:
      - bench/dbg_bus_tb.sv
